//--- flist.f
+incdir+.
icache_pkg.sv
icache_tag_way.sv
icache_data_way.sv
icache_age_table.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

//--- Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - files:
      - icache_pkg.sv
      - icache_tag_way.sv
      - icache_data_way.sv
      - icache_age_table.sv
      - icache_refill.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    files:
      - tb_icache.sv

//--- tb_icache.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module tb_icache;
    import icache_pkg::*;

    localparam int N_RANDOM    = 400;
    localparam int N_DIRECTED  = 12;
    localparam int FENCE_EVERY = 100;
    localparam int N_FENCE     = N_RANDOM / FENCE_EVERY + 1;
    // 200 ns per request plus the sweep of every fence
    localparam int RUN_LIMIT_NS = (N_RANDOM + N_DIRECTED) * 200 + N_FENCE * 70 * 4 + 100;

    logic       clk;
    logic       rst_n_i;
    logic       fetch_req_i;
    addr_t      fetch_addr_i;
    logic       issue_ready_i;
    logic       fetch_valid_o;
    fetch_rsp_t fetch_rsp_o;
    logic       fence_i;
    logic       mem_req_o;
    addr_t      mem_addr_o;
    logic       mem_valid_i;
    beat_t      mem_rdata_i;

    // reference cache state
    logic       m_valid [2][`ICACHE_SETS];
    tag_t       m_tag   [2][`ICACHE_SETS];
    age_t       m_age   [2][`ICACHE_SETS];
    addr_t      beat_log [$];

    icache_top i_icache_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .issue_ready_i (issue_ready_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_rsp_o   (fetch_rsp_o),
        .fence_i       (fence_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i),
        .mem_rdata_i   (mem_rdata_i)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ************************************************************
    // memory contents and address helpers
    // ************************************************************

    function automatic logic [31:0] mem_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h1234_5678;
    endfunction

    function automatic line_t expected_line(input addr_t a);
        addr_t base;
        addr_t wa;
        line_t l;
        base = {a[31:4], 4'h0};
        for (int k = 0; k < 4; k++) begin
            wa = base + 4 * k;
            l[32*k +: 32] = mem_word(wa);
        end
        return l;
    endfunction

    function automatic addr_t make_addr(input tag_t tag, input index_t idx, input logic [1:0] w);
        return {tag, idx, w, 2'b00};
    endfunction

    // few tags over few sets so that sets overflow
    function automatic addr_t random_addr();
        tag_t   tag;
        index_t idx;
        case ($urandom_range(3, 0))
            0: tag = 22'h000000;
            1: tag = 22'h000001;
            2: tag = 22'h0002a5;
            default: tag = 22'h3fffff;
        endcase
        case ($urandom_range(2, 0))
            0: idx = 6'd0;
            1: idx = 6'd17;
            default: idx = 6'd63;
        endcase
        return make_addr(tag, idx, 2'($urandom_range(3, 0)));
    endfunction

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR @%0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // ************************************************************
    // reference model
    // ************************************************************

    task automatic model_clear(input bit with_ages);
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                m_valid[w][s] = 1'b0;
                if (with_ages) begin
                    m_tag[w][s] = '0;
                    m_age[w][s] = '0;
                end
            end
        end
    endtask

    // finds the way of the line, a miss fills the victim
    task automatic model_access(input addr_t a, output bit hit, output int way);
        index_t s;
        s   = a[9:4];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][s] && (m_tag[w][s] == a[31:10])) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            if (!m_valid[0][s]) begin
                way = 0;
            end else if (!m_valid[1][s]) begin
                way = 1;
            end else begin
                way = (m_age[0][s] >= m_age[1][s]) ? 0 : 1;
            end
            m_valid[way][s] = 1'b1;
            m_tag[way][s]   = a[31:10];
            m_age[way][s]   = '0;
        end
    endtask

    task automatic model_deliver(input index_t idx, input int way);
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                if ((w == way) && (s == idx)) begin
                    m_age[w][s] = '0;
                end else if (m_age[w][s] != 3'd7) begin
                    m_age[w][s] = m_age[w][s] + 1'b1;
                end
            end
        end
    endtask

    // ************************************************************
    // stimulus, responder and checks
    // ************************************************************

    task automatic check_response(input addr_t a);
        addr_t pc_exp;
        check_equal(fetch_rsp_o.data, expected_line(a), "fetch group data");
        for (int k = 0; k < 4; k++) begin
            pc_exp = a + 4 * k;
            check_equal(fetch_rsp_o.pc[k], pc_exp, "fetch group pc");
        end
    endtask

    task automatic check_beats(input addr_t a, input bit hit);
        addr_t base;
        base = {a[31:4], 4'h0};
        if (hit) begin
            check_equal(beat_log.size(), 0, "memory beats on a hit");
        end else begin
            check_equal(beat_log.size(), 2, "memory beats on a miss");
            check_equal(beat_log[0], base, "beat 0 address");
            check_equal(beat_log[1], base | 32'h8, "beat 1 address");
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic run_request(input addr_t a, input bit random_ready,
                               output bit hit, output int cycles);
        int way;
        bit done;
        model_access(a, hit, way);
        beat_log.delete();
        fetch_req_i   = 1'b1;
        fetch_addr_i  = a;
        issue_ready_i = random_ready ? ($urandom_range(4, 0) < 3) : 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (fetch_valid_o) begin
                check_equal(issue_ready_i, 1'b1, "valid without issue ready");
                check_response(a);
                check_beats(a, hit);
                model_deliver(a[9:4], way);
                done = 1'b1;
            end
            @(posedge clk);
            #1;
            if (!done) begin
                cycles++;
                if (random_ready) begin
                    issue_ready_i = ($urandom_range(4, 0) < 3);
                end
            end
        end
        fetch_req_i   = 1'b0;
        issue_ready_i = 1'b0;
    endtask

    task automatic stalled_hit(input addr_t a, input int hold);
        bit hit;
        int way;
        model_access(a, hit, way);
        check_equal(hit, 1'b1, "stalled access predicted as hit");
        beat_log.delete();
        fetch_req_i   = 1'b1;
        fetch_addr_i  = a;
        issue_ready_i = 1'b0;
        repeat (hold) begin
            @(negedge clk);
            check_equal(fetch_valid_o, 1'b0, "valid under back-pressure");
            @(posedge clk);
            #1;
        end
        issue_ready_i = 1'b1;
        @(negedge clk);
        check_equal(fetch_valid_o, 1'b1, "valid in the cycle issue ready rises");
        check_response(a);
        check_beats(a, 1'b1);
        model_deliver(a[9:4], way);
        @(posedge clk);
        #1;
        fetch_req_i   = 1'b0;
        issue_ready_i = 1'b0;
    endtask

    // the controller is in IDLE whenever this is called
    // the next request is held through the sweep, the fence has to win
    task automatic send_fence(input addr_t next_a);
        model_clear(1'b0);
        fence_i       = 1'b1;
        fetch_req_i   = 1'b1;
        fetch_addr_i  = next_a;
        issue_ready_i = 1'b1;
        @(posedge clk);
        #1;
        fence_i = 1'b0;
        repeat (64) begin
            @(negedge clk);
            check_equal(fetch_valid_o, 1'b0, "valid during fence sweep");
            check_equal(mem_req_o, 1'b0, "memory request during fence sweep");
            @(posedge clk);
        end
        #1;
    endtask

    task automatic mem_responder();
        int    delay;
        addr_t a;
        forever begin
            @(posedge clk);
            #1;
            mem_valid_i = 1'b0;
            if (mem_req_o) begin
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                a = mem_addr_o;
                beat_log.push_back(a);
                mem_valid_i = 1'b1;
                mem_rdata_i = {mem_word(a + 4), mem_word(a)};
            end
        end
    endtask

    task automatic watchdog();
        #(RUN_LIMIT_NS);
        $display("timeout after %0d ns, the cache stopped answering requests", RUN_LIMIT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    initial begin : main
        addr_t a_addr;
        addr_t b_addr;
        addr_t c_addr;
        addr_t d_addr;
        addr_t e_addr;
        addr_t r_addr;
        bit    hit;
        int    cycles;
        void'($urandom(76229));
        rst_n_i       = 1'b0;
        fetch_req_i   = 1'b0;
        fetch_addr_i  = '0;
        issue_ready_i = 1'b1;
        fence_i       = 1'b0;
        mem_valid_i   = 1'b0;
        mem_rdata_i   = '0;
        model_clear(1'b1);
        fork
            watchdog();
        join_none
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        fork
            mem_responder();
        join_none
        @(negedge clk);
        check_equal(fetch_valid_o, 1'b0, "fetch_valid_o after reset");
        check_equal(mem_req_o, 1'b0, "mem_req_o after reset");
        @(posedge clk);
        #1;

        // three tags in one set
        a_addr = make_addr(22'h000abc, 6'd5, 2'd0);
        b_addr = make_addr(22'h000def, 6'd5, 2'd1);
        c_addr = make_addr(22'h001234, 6'd5, 2'd3);
        run_request(a_addr, 1'b0, hit, cycles);
        check_equal(hit, 1'b0, "first access after reset is a miss");
        run_request(b_addr, 1'b0, hit, cycles);
        check_equal(hit, 1'b0, "second tag misses");
        run_request(a_addr, 1'b0, hit, cycles);
        check_equal(hit, 1'b1, "refilled line hits");
        check_equal(cycles, 3, "hit latency in cycles");
        run_request(c_addr, 1'b0, hit, cycles);
        check_equal(hit, 1'b0, "third tag misses");
        run_request(a_addr, 1'b0, hit, cycles);
        check_equal(hit, 1'b1, "recently used tag is kept");
        run_request(b_addr, 1'b0, hit, cycles);
        check_equal(hit, 1'b0, "older tag was evicted");
        stalled_hit(a_addr, 8);

        // fence drops every line
        d_addr = make_addr(22'h000002, 6'd40, 2'd2);
        e_addr = make_addr(22'h000003, 6'd41, 2'd0);
        run_request(d_addr, 1'b1, hit, cycles);
        run_request(e_addr, 1'b1, hit, cycles);
        send_fence(a_addr);
        run_request(a_addr, 1'b1, hit, cycles);
        check_equal(hit, 1'b0, "line a after fence");
        run_request(d_addr, 1'b1, hit, cycles);
        check_equal(hit, 1'b0, "line d after fence");
        run_request(e_addr, 1'b1, hit, cycles);
        check_equal(hit, 1'b0, "line e after fence");

        for (int n = 0; n < N_RANDOM; n++) begin
            r_addr = random_addr();
            if ((n % FENCE_EVERY) == (FENCE_EVERY - 1)) begin
                send_fence(r_addr);
            end
            run_request(r_addr, 1'b1, hit, cycles);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  icache_pkg::addr_t      fetch_addr_i,
    input  logic                   issue_ready_i,
    output logic                   fetch_valid_o,
    output icache_pkg::fetch_rsp_t fetch_rsp_o,
    input  logic                   fence_i,
    output logic                   mem_req_o,
    output icache_pkg::addr_t      mem_addr_o,
    input  logic                   mem_valid_i,
    input  icache_pkg::beat_t      mem_rdata_i
);
    import icache_pkg::*;

    index_t     rd_index;
    index_t     wr_index;
    way_mask_t  wr_mask;
    tag_entry_t wr_entry;
    tag_entry_t way0_entry;
    tag_entry_t way1_entry;
    line_t      way0_line;
    line_t      way1_line;
    line_t      refill_line;
    way_mask_t  victim;
    way_mask_t  hit_way;
    logic       deliver;
    logic       fill;
    logic       refill_start;
    logic       refill_done;

    // ***********************************************************
    // tag and data arrays
    // ***********************************************************

    icache_tag_way u_tag_way0 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_mask[0]),
        .wr_index_i (wr_index),
        .wr_entry_i (wr_entry),
        .rd_entry_o (way0_entry)
    );

    icache_tag_way u_tag_way1 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_mask[1]),
        .wr_index_i (wr_index),
        .wr_entry_i (wr_entry),
        .rd_entry_o (way1_entry)
    );

    icache_data_way u_data_way0 (
        .clk        (clk),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_mask[0]),
        .wr_index_i (wr_index),
        .wr_line_i  (refill_line),
        .rd_line_o  (way0_line)
    );

    icache_data_way u_data_way1 (
        .clk        (clk),
        .rd_index_i (rd_index),
        .wr_en_i    (wr_mask[1]),
        .wr_index_i (wr_index),
        .wr_line_i  (refill_line),
        .rd_line_o  (way1_line)
    );

    // ***********************************************************
    // replacement, refill and control
    // ***********************************************************

    icache_age_table u_age_table (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .index_i    (rd_index),
        .deliver_i  (deliver),
        .hit_way_i  (hit_way),
        .fill_i     (fill),
        .fill_way_i (wr_mask),
        .valid_i    ({way1_entry.valid, way0_entry.valid}),
        .victim_o   (victim)
    );

    icache_refill u_refill (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (refill_start),
        .line_addr_i (fetch_addr_i),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_i (mem_valid_i),
        .mem_rdata_i (mem_rdata_i),
        .line_o      (refill_line),
        .done_o      (refill_done)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .issue_ready_i  (issue_ready_i),
        .fence_i        (fence_i),
        .way0_entry_i   (way0_entry),
        .way1_entry_i   (way1_entry),
        .way0_line_i    (way0_line),
        .way1_line_i    (way1_line),
        .victim_i       (victim),
        .refill_done_i  (refill_done),
        .rd_index_o     (rd_index),
        .wr_mask_o      (wr_mask),
        .wr_index_o     (wr_index),
        .wr_entry_o     (wr_entry),
        .refill_start_o (refill_start),
        .deliver_o      (deliver),
        .hit_way_o      (hit_way),
        .fill_o         (fill),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_rsp_o    (fetch_rsp_o)
    );

endmodule

//--- icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   fetch_req_i,
    input  icache_pkg::addr_t      fetch_addr_i,
    input  logic                   issue_ready_i,
    input  logic                   fence_i,
    input  icache_pkg::tag_entry_t way0_entry_i,
    input  icache_pkg::tag_entry_t way1_entry_i,
    input  icache_pkg::line_t      way0_line_i,
    input  icache_pkg::line_t      way1_line_i,
    input  icache_pkg::way_mask_t  victim_i,
    input  logic                   refill_done_i,
    output icache_pkg::index_t     rd_index_o,
    output icache_pkg::way_mask_t  wr_mask_o,
    output icache_pkg::index_t     wr_index_o,
    output icache_pkg::tag_entry_t wr_entry_o,
    output logic                   refill_start_o,
    output logic                   deliver_o,
    output icache_pkg::way_mask_t  hit_way_o,
    output logic                   fill_o,
    output logic                   fetch_valid_o,
    output icache_pkg::fetch_rsp_t fetch_rsp_o
);
    import icache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        wait_q;
    index_t      sweep_q;
    tag_t        addr_tag;
    index_t      addr_index;
    logic        hit0;
    logic        hit1;
    logic        any_hit;
    logic        compare;

    assign addr_tag   = fetch_addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign addr_index = fetch_addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // way 0 wins if both ever match
    assign hit0      = way0_entry_i.valid && (way0_entry_i.tag == addr_tag);
    assign hit1      = way1_entry_i.valid && (way1_entry_i.tag == addr_tag);
    assign hit_way_o = {hit1 && !hit0, hit0};
    assign any_hit   = hit0 || hit1;
    assign compare   = (state_q == LOOKUP) && wait_q;

    // ***********************************************************
    // lookup FSM
    // ***********************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fence_i) begin
                    state_d = FENCE;
                end else if (fetch_req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (wait_q) begin
                    state_d = any_hit ? HIT : REFILL;
                end
            end
            HIT: begin
                if (issue_ready_i) begin
                    state_d = IDLE;
                end
            end
            REFILL: begin
                if (refill_done_i) begin
                    state_d = LOOKUP;
                end
            end
            FENCE: begin
                if (sweep_q == '1) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            wait_q  <= 1'b0;
            sweep_q <= '0;
        end else begin
            state_q <= state_d;
            // first LOOKUP cycle only waits for the read
            wait_q  <= (state_q == LOOKUP) && !wait_q;
            sweep_q <= (state_q == FENCE) ? sweep_q + 1'b1 : '0;
        end
    end

    // ***********************************************************
    // array access and outputs
    // ***********************************************************

    assign rd_index_o = (state_q == FENCE) ? sweep_q : addr_index;
    assign wr_index_o = (state_q == FENCE) ? sweep_q : addr_index;

    assign refill_start_o = compare && !any_hit;
    assign fill_o         = (state_q == REFILL) && refill_done_i;

    always_comb begin
        if (state_q == FENCE) begin
            wr_mask_o        = 2'b11;
            wr_entry_o.valid = 1'b0;
            wr_entry_o.tag   = '0;
        end else begin
            wr_mask_o        = fill_o ? victim_i : 2'b00;
            wr_entry_o.valid = 1'b1;
            wr_entry_o.tag   = addr_tag;
        end
    end

    assign deliver_o     = (state_q == HIT) && issue_ready_i;
    assign fetch_valid_o = deliver_o;

    always_comb begin
        fetch_rsp_o.data = hit_way_o[1] ? way1_line_i : way0_line_i;
        for (int k = 0; k < 4; k++) begin
            fetch_rsp_o.pc[k] = fetch_addr_i + addr_t'(4 * k);
        end
    end

endmodule

//--- icache_refill.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_refill (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              start_i,
    input  icache_pkg::addr_t line_addr_i,
    output logic              mem_req_o,
    output icache_pkg::addr_t mem_addr_o,
    input  logic              mem_valid_i,
    input  icache_pkg::beat_t mem_rdata_i,
    output icache_pkg::line_t line_o,
    output logic              done_o
);
    import icache_pkg::*;

    localparam int LINE_NUM_W = `ICACHE_ADDR_W - `ICACHE_OFFSET_W;

    logic                  active_q;
    logic                  beat_q;
    logic                  done_q;
    logic [LINE_NUM_W-1:0] line_num_q;
    line_t                 line_q;
    logic                  launch;
    logic                  accept;

    assign launch = start_i && !active_q;
    assign accept = active_q && mem_valid_i;

    // ***********************************************************
    // beat sequencer
    // ***********************************************************

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            beat_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (launch) begin
                active_q <= 1'b1;
                beat_q   <= 1'b0;
            end else if (accept) begin
                // second beat closes the burst
                if (beat_q) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
                beat_q <= ~beat_q;
            end
        end
    end

    // line address and assembled data
    always_ff @(posedge clk) begin
        if (launch) begin
            line_num_q <= line_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W];
        end
        if (accept) begin
            line_q[beat_q * `ICACHE_BEAT_W +: `ICACHE_BEAT_W] <= mem_rdata_i;
        end
    end

    // beat 0 has bit 3 clear, beat 1 has it set
    assign mem_req_o  = active_q;
    assign mem_addr_o = {line_num_q, beat_q, 3'b000};
    assign line_o     = line_q;
    assign done_o     = done_q;

endmodule

//--- icache_age_table.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_age_table (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  icache_pkg::index_t    index_i,
    input  logic                  deliver_i,
    input  icache_pkg::way_mask_t hit_way_i,
    input  logic                  fill_i,
    input  icache_pkg::way_mask_t fill_way_i,
    input  logic [1:0]            valid_i,
    output icache_pkg::way_mask_t victim_o
);
    import icache_pkg::*;

    localparam age_t AGE_MAX = '1;

    age_t age_q [`ICACHE_WAYS][`ICACHE_SETS];
    age_t age0;
    age_t age1;

    // ***********************************************************
    // age update
    // ***********************************************************

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    // every delivery ages the whole table
                    if (deliver_i) begin
                        if (hit_way_i[w] && (index_t'(s) == index_i)) begin
                            age_q[w][s] <= '0;
                        end else if (age_q[w][s] != AGE_MAX) begin
                            age_q[w][s] <= age_q[w][s] + 1'b1;
                        end
                    end
                    if (fill_i && fill_way_i[w] && (index_t'(s) == index_i)) begin
                        age_q[w][s] <= '0;
                    end
                end
            end
        end
    end

    // victim choice, invalid ways first
    assign age0 = age_q[0][index_i];
    assign age1 = age_q[1][index_i];

    always_comb begin
        if (!valid_i[0]) begin
            victim_o = 2'b01;
        end else if (!valid_i[1]) begin
            victim_o = 2'b10;
        end else if (age0 >= age1) begin
            victim_o = 2'b01;
        end else begin
            victim_o = 2'b10;
        end
    end

endmodule

//--- icache_data_way.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_data_way (
    input  logic               clk,
    input  icache_pkg::index_t rd_index_i,
    input  logic               wr_en_i,
    input  icache_pkg::index_t wr_index_i,
    input  icache_pkg::line_t  wr_line_i,
    output icache_pkg::line_t  rd_line_o
);
    import icache_pkg::*;

    line_t mem_q [`ICACHE_SETS];
    line_t rd_line_q;

    // ***********************************************************
    // single port style line store
    // ***********************************************************

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_index_i] <= wr_line_i;
        end
    end

    // read returns the old line when the same set is written
    always_ff @(posedge clk) begin
        rd_line_q <= mem_q[rd_index_i];
    end

    assign rd_line_o = rd_line_q;

endmodule

//--- icache_tag_way.sv
`timescale 1ns/1ps
`include "icache_cfg.svh"

module icache_tag_way (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  icache_pkg::index_t     rd_index_i,
    input  logic                   wr_en_i,
    input  icache_pkg::index_t     wr_index_i,
    input  icache_pkg::tag_entry_t wr_entry_i,
    output icache_pkg::tag_entry_t rd_entry_o
);
    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0] valid_q;
    tag_t                    tag_q [`ICACHE_SETS];
    logic                    rd_valid_q;
    tag_t                    rd_tag_q;

    // valid bits, cleared on reset and by a fence write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_index_i] <= wr_entry_i.valid;
            end
            rd_valid_q <= valid_q[rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_index_i] <= wr_entry_i.tag;
        end
        rd_tag_q <= tag_q[rd_index_i];
    end

    assign rd_entry_o.valid = rd_valid_q;
    assign rd_entry_o.tag   = rd_tag_q;

endmodule

//--- icache_pkg.sv
`include "icache_cfg.svh"

package icache_pkg;

    // ***********************************************************
    // vector types
    // ***********************************************************

    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic [`ICACHE_BEAT_W-1:0]  beat_t;
    typedef logic [`ICACHE_AGE_W-1:0]   age_t;
    // one-hot, bit 0 is way 0
    typedef logic [`ICACHE_WAYS-1:0]    way_mask_t;

    // ***********************************************************
    // structs
    // ***********************************************************

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // pc[k] is the fetch address plus 4k
    typedef struct packed {
        line_t     data;
        addr_t [3:0] pc;
    } fetch_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        REFILL,
        FENCE
    } ctrl_state_e;

endpackage

//--- icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// ***********************************************************
// address split
// ***********************************************************

// fetch and memory address width
`define ICACHE_ADDR_W   32
// tag is addr[31:10]
`define ICACHE_TAG_W    22
// set index is addr[9:4]
`define ICACHE_INDEX_W  6
`define ICACHE_OFFSET_W 4

// ***********************************************************
// geometry
// ***********************************************************

`define ICACHE_SETS     64
`define ICACHE_WAYS     2
`define ICACHE_LINE_W   128
`define ICACHE_BEAT_W   64
// age counters saturate at 7
`define ICACHE_AGE_W    3

`endif
